/* bankAddrGen.sv */
`timescale 1ns/1ps

module bankAddrGen #(
	parameter int frameRows = parserPkg::defFrameRows,
	parameter int frameCols = parserPkg::defFrameCols
) (
	input logic clk,
	input logic rstn,
	scanIf.user scanIn,
	output logic [parserPkg::numBanks-1:0] bankCs,
	output parserPkg::bankAddr bankAddr [parserPkg::numBanks]
);
	import parserPkg::*;

	logic [numBanks-1:0] nextCs;
	logic [addrW-1:0] nextAddr [numBanks];

	// each bank holds exactly one pixel of a 4x4 window
	always_comb begin
		logic [1:0] rowOff;
		logic [1:0] colOff;
		int pixY;
		int pixX;
		for (int b = 0; b < numBanks; b++) begin
			// slot row/col of this bank, (phase - window origin) mod 4
			rowOff = 2'(b >> 2) - {scanIn.winRow[0], 1'b0} + 2'd1;
			colOff = 2'(b) - {scanIn.winCol[0], 1'b0} + 2'd1;
			pixY = 2 * int'(scanIn.winRow) - 1 + int'(rowOff);
			pixX = 2 * int'(scanIn.winCol) - 1 + int'(colOff);
			nextCs[b] = !(((scanIn.rowKind == sRowTop) && (rowOff == 2'd0))
				|| ((scanIn.rowKind == sRowBottom) && (pixY >= frameRows))
				|| ((scanIn.winCol == '0) && (colOff == 2'd0))
				|| ((scanIn.winCol == addrW'(frameCols / 2 - 1)) && (colOff == 2'd3)));
			if (nextCs[b])
				nextAddr[b] = addrW'((pixY / 4) * (frameCols / 4) + pixX / 4);
			else
				nextAddr[b] = '0;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			bankCs <= '0;
		else
			bankCs <= scanIn.valid ? nextCs : '0; // idle cycles read nothing
	end

	always_ff @(posedge clk) begin
		if (scanIn.valid) begin
			for (int b = 0; b < numBanks; b++)
				bankAddr[b] <= nextAddr[b];
		end
	end

endmodule

/* featureParser.sv */
`timescale 1ns/1ps

module featureParser #(
	parameter int frameRows = parserPkg::defFrameRows,
	parameter int frameCols = parserPkg::defFrameCols,
	parameter int creditDepth = parserPkg::defCredits
) (
	input logic clk,
	input logic rstn,
	input logic start,
	input logic creditReturn, // one credit back from MAC array
	input parserPkg::pixelWord bankData [parserPkg::numBanks],
	output logic [parserPkg::numBanks-1:0] bankCs,
	output parserPkg::bankAddr bankAddr [parserPkg::numBanks],
	output logic winValid,
	output parserPkg::pixelWord winData [parserPkg::numBanks],
	output logic winLast
);

	scanIf scanBus ();
	routeIf routeBus ();

	////////////////////////////////////////////////////////////
	// issue, address and route
	////////////////////////////////////////////////////////////
	scanSequencer #(
		.frameRows(frameRows),
		.frameCols(frameCols),
		.creditDepth(creditDepth)
	) i_scanSequencer (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.creditReturn(creditReturn),
		.scanOut(scanBus.seq)
	);

	bankAddrGen #(
		.frameRows(frameRows),
		.frameCols(frameCols)
	) i_bankAddrGen (
		.clk(clk),
		.rstn(rstn),
		.scanIn(scanBus.user),
		.bankCs(bankCs),
		.bankAddr(bankAddr)
	);

	windowRouteGen #(
		.frameRows(frameRows),
		.frameCols(frameCols)
	) i_windowRouteGen (
		.clk(clk),
		.rstn(rstn),
		.scanIn(scanBus.user),
		.routeOut(routeBus.gen)
	);

	////////////////////////////////////////////////////////////
	// window output
	////////////////////////////////////////////////////////////
	windowAssembler i_windowAssembler (
		.clk(clk),
		.rstn(rstn),
		.bankData(bankData),
		.routeIn(routeBus.asm),
		.winValid(winValid),
		.winData(winData),
		.winLast(winLast)
	);

endmodule

/* flist.f */
parserPkg.sv
scanIf.sv
routeIf.sv
scanSequencer.sv
bankAddrGen.sv
windowRouteGen.sv
windowAssembler.sv
featureParser.sv
parserChecker.sv
tb_featureParser.sv

/* parserChecker.sv */
`timescale 1ns/1ps

module parserChecker #(
	parameter int frameRows = parserPkg::defFrameRows,
	parameter int frameCols = parserPkg::defFrameCols,
	parameter int creditDepth = parserPkg::defCredits,
	parameter int patWords = 160
) (
	input logic clk,
	input logic rstn,
	input logic [parserPkg::numBanks-1:0] bankCs,
	input parserPkg::bankAddr bankAddr [parserPkg::numBanks],
	input logic winValid,
	input parserPkg::pixelWord winData [parserPkg::numBanks],
	input logic winLast,
	input logic creditReturn,
	input logic [31:0] pat [patWords],
	output int dataErr,
	output int csErr,
	output int creditErr,
	output int ctrlErr,
	output int winCount
);
	import parserPkg::*;

	localparam int winPerFrame = (frameRows / 2) * (frameCols / 2);
	localparam int frameWords = frameRows * frameCols;

	int csCount;
	int outstanding;
	logic prevRstn;

	// frame coordinate of slot row/col i in window k (can fall outside)
	function automatic int pixRow(input int k, input int i);
		return 2 * (k / (frameCols / 2)) - 1 + i;
	endfunction

	function automatic int pixCol(input int k, input int j);
		return 2 * (k % (frameCols / 2)) - 1 + j;
	endfunction

	function automatic bit inFrame(input int y, input int x);
		return (y >= 0) && (y < frameRows) && (x >= 0) && (x < frameCols);
	endfunction

	////////////////////////////////////////////////////////////
	// reset and control
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		prevRstn <= rstn;
		if (!rstn || !prevRstn) begin
			if (winValid || winLast || (bankCs != '0)) begin
				$display("Fail t=%0t winValid/winLast/bankCs exp 0/0/0000 got %b/%b/%h",
					$time, winValid, winLast, bankCs);
				ctrlErr++;
			end
		end
		if (rstn && winLast && !winValid) begin
			$display("winLast seen without winValid at t=%0t", $time);
			ctrlErr++;
		end
	end

	////////////////////////////////////////////////////////////
	// window data, padding and last flag
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		int k;
		int base;
		if (rstn && winValid) begin
			k = winCount % winPerFrame;
			base = frameWords + 16 * k;
			for (int s = 0; s < numBanks; s++) begin
				if (winData[s] !== pat[base + s]) begin
					$display("Fail t=%0t winData[%0d] exp %h got %h",
						$time, s, pat[base + s], winData[s]);
					dataErr++;
				end
				if (!inFrame(pixRow(k, s / 4), pixCol(k, s % 4)) && (winData[s] !== '0)) begin
					$display("Fail t=%0t winData[%0d] exp %h got %h", $time, s, 32'h0,
						winData[s]);
					dataErr++;
				end
			end
			if (winLast !== (k == winPerFrame - 1)) begin
				$display("Fail t=%0t winLast exp %b got %b", $time,
					(k == winPerFrame - 1), winLast);
				ctrlErr++;
			end
			winCount++;
		end
	end

	////////////////////////////////////////////////////////////
	// chip selects, addresses and credits
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		int k;
		int i;
		int j;
		int expAddr;
		bit expCs;
		if (rstn && (bankCs != '0)) begin
			k = csCount % winPerFrame;
			for (int b = 0; b < numBanks; b++) begin
				// slot of the one pixel this bank holds in window k
				i = ((b / 4) - pixRow(k, 0) + 8) % 4;
				j = ((b % 4) - pixCol(k, 0) + 8) % 4;
				expCs = inFrame(pixRow(k, i), pixCol(k, j));
				expAddr = (pixRow(k, i) / 4) * (frameCols / 4) + pixCol(k, j) / 4;
				if (bankCs[b] !== expCs) begin
					$display("Fail t=%0t bankCs[%0d] exp %b got %b", $time, b, expCs,
						bankCs[b]);
					csErr++;
				end
				if (expCs && (bankAddr[b] !== addrW'(expAddr))) begin
					$display("Fail t=%0t bankAddr[%0d] exp %0d got %0d", $time, b, expAddr,
						bankAddr[b]);
					csErr++;
				end
			end
			csCount++;
		end
		if (rstn) begin
			outstanding = outstanding + (winValid ? 1 : 0) - (creditReturn ? 1 : 0);
			if (outstanding > creditDepth) begin
				$display("Fail t=%0t outstanding exp <=%0d got %0d", $time, creditDepth,
					outstanding);
				creditErr++;
			end
		end
	end

	initial begin
		dataErr = 0;
		csErr = 0;
		creditErr = 0;
		ctrlErr = 0;
		winCount = 0;
		csCount = 0;
		outstanding = 0;
		prevRstn = 1'b0;
	end

endmodule

/* parserPkg.sv */
package parserPkg;

	////////////////////////////////////////////////////////////
	// bank and window geometry
	////////////////////////////////////////////////////////////
	localparam int numBanks = 16; // banks per frame, slots per window
	localparam int chanW = 8;
	localparam int addrW = 8;

	typedef logic [4*chanW-1:0] pixelWord; // four channels per pixel
	typedef logic [3:0] bankIdx;
	typedef logic [addrW-1:0] bankAddr;

	////////////////////////////////////////////////////////////
	// scan states
	////////////////////////////////////////////////////////////
	// the three row states double as the row kind of a window
	typedef enum logic [2:0] {
		sIdle,
		sRowTop, // first window row, pads on top
		sRowMid,
		sRowBottom, // last window row, pads at bottom
		sDone
	} scanState;

	////////////////////////////////////////////////////////////
	// defaults for the top level
	////////////////////////////////////////////////////////////
	localparam int defFrameRows = 4; // multiple of 4
	localparam int defFrameCols = 8; // multiple of 4
	localparam int defCredits = 4;

endpackage

/* patterns_frame.hex */
// frame: 4 rows of 8 pixel words, pixel (y,x) is AyBxCyDx
// then 8 windows in row-major order, 16 slots each, one line per slot row
A0B0C0D0 A0B1C0D1 A0B2C0D2 A0B3C0D3 A0B4C0D4 A0B5C0D5 A0B6C0D6 A0B7C0D7
A1B0C1D0 A1B1C1D1 A1B2C1D2 A1B3C1D3 A1B4C1D4 A1B5C1D5 A1B6C1D6 A1B7C1D7
A2B0C2D0 A2B1C2D1 A2B2C2D2 A2B3C2D3 A2B4C2D4 A2B5C2D5 A2B6C2D6 A2B7C2D7
A3B0C3D0 A3B1C3D1 A3B2C3D2 A3B3C3D3 A3B4C3D4 A3B5C3D5 A3B6C3D6 A3B7C3D7
// window (0,0)
00000000 00000000 00000000 00000000
00000000 A0B0C0D0 A0B1C0D1 A0B2C0D2
00000000 A1B0C1D0 A1B1C1D1 A1B2C1D2
00000000 A2B0C2D0 A2B1C2D1 A2B2C2D2
// window (0,1)
00000000 00000000 00000000 00000000
A0B1C0D1 A0B2C0D2 A0B3C0D3 A0B4C0D4
A1B1C1D1 A1B2C1D2 A1B3C1D3 A1B4C1D4
A2B1C2D1 A2B2C2D2 A2B3C2D3 A2B4C2D4
// window (0,2)
00000000 00000000 00000000 00000000
A0B3C0D3 A0B4C0D4 A0B5C0D5 A0B6C0D6
A1B3C1D3 A1B4C1D4 A1B5C1D5 A1B6C1D6
A2B3C2D3 A2B4C2D4 A2B5C2D5 A2B6C2D6
// window (0,3)
00000000 00000000 00000000 00000000
A0B5C0D5 A0B6C0D6 A0B7C0D7 00000000
A1B5C1D5 A1B6C1D6 A1B7C1D7 00000000
A2B5C2D5 A2B6C2D6 A2B7C2D7 00000000
// window (1,0)
00000000 A1B0C1D0 A1B1C1D1 A1B2C1D2
00000000 A2B0C2D0 A2B1C2D1 A2B2C2D2
00000000 A3B0C3D0 A3B1C3D1 A3B2C3D2
00000000 00000000 00000000 00000000
// window (1,1)
A1B1C1D1 A1B2C1D2 A1B3C1D3 A1B4C1D4
A2B1C2D1 A2B2C2D2 A2B3C2D3 A2B4C2D4
A3B1C3D1 A3B2C3D2 A3B3C3D3 A3B4C3D4
00000000 00000000 00000000 00000000
// window (1,2)
A1B3C1D3 A1B4C1D4 A1B5C1D5 A1B6C1D6
A2B3C2D3 A2B4C2D4 A2B5C2D5 A2B6C2D6
A3B3C3D3 A3B4C3D4 A3B5C3D5 A3B6C3D6
00000000 00000000 00000000 00000000
// window (1,3)
A1B5C1D5 A1B6C1D6 A1B7C1D7 00000000
A2B5C2D5 A2B6C2D6 A2B7C2D7 00000000
A3B5C3D5 A3B6C3D6 A3B7C3D7 00000000
00000000 00000000 00000000 00000000

/* routeIf.sv */
`timescale 1ns/1ps

interface routeIf;
	import parserPkg::*;

	logic valid; // aligned with bank read data
	bankIdx srcBank [numBanks]; // source bank per slot
	logic [numBanks-1:0] padMask; // slot lies outside the frame
	logic last;

	modport gen (
		output valid,
		output srcBank,
		output padMask,
		output last
	);

	modport asm (
		input valid,
		input srcBank,
		input padMask,
		input last
	);

endinterface

/* run.sh */
#!/usr/bin/env bash
# build and run the featureParser testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing \
	-f flist.f \
	--top-module tb_featureParser \
	-o simv

./obj_dir/simv | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

/* scanIf.sv */
`timescale 1ns/1ps

interface scanIf;
	import parserPkg::*;

	logic valid; // one cycle per issued window
	logic [addrW-1:0] winRow;
	logic [addrW-1:0] winCol;
	scanState rowKind;

	modport seq (
		output valid,
		output winRow,
		output winCol,
		output rowKind
	);

	modport user (
		input valid,
		input winRow,
		input winCol,
		input rowKind
	);

endinterface

/* scanSequencer.sv */
`timescale 1ns/1ps

module scanSequencer #(
	parameter int frameRows = parserPkg::defFrameRows,
	parameter int frameCols = parserPkg::defFrameCols,
	parameter int creditDepth = parserPkg::defCredits
) (
	input logic clk,
	input logic rstn,
	input logic start,
	input logic creditReturn,
	scanIf.seq scanOut
);
	import parserPkg::*;

	localparam int winRows = frameRows / 2;
	localparam int winCols = frameCols / 2;
	localparam int creditW = $clog2(creditDepth + 1);

	scanState state;
	logic [addrW-1:0] rowCnt;
	logic [addrW-1:0] colCnt;
	logic [creditW-1:0] credits;
	logic issue;
	logic rowEnd;
	logic frameEnd;

	assign issue = (state inside {sRowTop, sRowMid, sRowBottom}) && (credits != '0);
	assign rowEnd = colCnt == addrW'(winCols - 1);
	assign frameEnd = rowEnd && (rowCnt == addrW'(winRows - 1));

	////////////////////////////////////////////////////////////
	// scan FSM and window position
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= sIdle;
			rowCnt <= '0;
			colCnt <= '0;
		end else begin
			case (state)
				sIdle: begin
					if (start) begin
						state <= sRowTop;
						rowCnt <= '0;
						colCnt <= '0;
					end
				end
				sRowTop, sRowMid, sRowBottom: begin
					if (issue) begin
						if (rowEnd) begin
							colCnt <= '0;
							if (frameEnd) begin
								state <= sDone;
							end else begin
								rowCnt <= rowCnt + 1'b1;
								// next row is the last one
								if (rowCnt == addrW'(winRows - 2))
									state <= sRowBottom;
								else
									state <= sRowMid;
							end
						end else begin
							colCnt <= colCnt + 1'b1;
						end
					end
				end
				sDone: if (!start) state <= sIdle; // wait for start to drop
				default: state <= sIdle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// MAC-side credits
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			credits <= creditW'(creditDepth);
		end else begin
			case ({issue, creditReturn})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits; // none or both
			endcase
		end
	end

	assign scanOut.valid = issue;
	assign scanOut.winRow = rowCnt;
	assign scanOut.winCol = colCnt;
	assign scanOut.rowKind = state;

endmodule

/* tb_featureParser.sv */
`timescale 1ns/1ps

module tb_featureParser;
	import parserPkg::*;

	localparam int frameRows = defFrameRows;
	localparam int frameCols = defFrameCols;
	localparam int creditDepth = defCredits;
	localparam int winPerFrame = (frameRows / 2) * (frameCols / 2);
	localparam int patWords = frameRows * frameCols + 16 * winPerFrame;
	localparam int numFrames = 2;
	localparam int timeoutCycles = numFrames * winPerFrame * 12 + 100;

	logic clk;
	logic rstn;
	logic start;
	logic creditReturn;
	pixelWord bankData [numBanks];
	logic [numBanks-1:0] bankCs;
	logic [addrW-1:0] bankAddr [numBanks];
	logic winValid;
	pixelWord winData [numBanks];
	logic winLast;

	logic [31:0] pat [patWords];
	logic [31:0] rndState;
	int owed;
	int delay;
	int cycles;
	int dataErr;
	int csErr;
	int creditErr;
	int ctrlErr;
	int winCount;
	int frameErr;
	int total;

	featureParser #(
		.frameRows(frameRows),
		.frameCols(frameCols),
		.creditDepth(creditDepth)
	) i_featureParser (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.creditReturn(creditReturn),
		.bankData(bankData),
		.bankCs(bankCs),
		.bankAddr(bankAddr),
		.winValid(winValid),
		.winData(winData),
		.winLast(winLast)
	);

	parserChecker #(
		.frameRows(frameRows),
		.frameCols(frameCols),
		.creditDepth(creditDepth),
		.patWords(patWords)
	) i_parserChecker (
		.clk(clk),
		.rstn(rstn),
		.bankCs(bankCs),
		.bankAddr(bankAddr),
		.winValid(winValid),
		.winData(winData),
		.winLast(winLast),
		.creditReturn(creditReturn),
		.pat(pat),
		.dataErr(dataErr),
		.csErr(csErr),
		.creditErr(creditErr),
		.ctrlErr(ctrlErr),
		.winCount(winCount)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// pixel stored at address a of bank b
	function automatic int pixIndex(input int b, input int a);
		int y;
		int x;
		y = 4 * (a / (frameCols / 4)) + b / 4;
		x = 4 * (a % (frameCols / 4)) + b % 4;
		return y * frameCols + x;
	endfunction

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// BRAM model and MAC-side credit return
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		for (int b = 0; b < numBanks; b++) begin
			rndState = xorshift(rndState);
			if (bankCs[b])
				bankData[b] <= pat[pixIndex(b, int'(bankAddr[b]))];
			else
				bankData[b] <= rndState; // garbage from unselected banks
		end
		creditReturn <= 1'b0;
		if (rstn) begin
			if (winValid)
				owed++;
			if (owed > 0) begin
				if (delay == 0) begin
					creditReturn <= 1'b1;
					owed--;
					rndState = xorshift(rndState);
					delay = int'(rndState[2:0]); // 0 to 7 cycles
				end else begin
					delay--;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeoutCycles) begin
			$display("run did not finish within %0d cycles", timeoutCycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		rndState = 32'd51;
		owed = 0;
		delay = 0;
		cycles = 0;
		frameErr = 0;
		rstn = 1'b0;
		start = 1'b0;
		creditReturn = 1'b0;
		for (int b = 0; b < numBanks; b++)
			bankData[b] <= '0;
		$readmemh("patterns_frame.hex", pat);
		repeat (4) @(posedge clk);
		rstn <= 1'b1;
		for (int f = 0; f < numFrames; f++) begin
			@(posedge clk);
			start <= 1'b1;
			do
				@(posedge clk);
			while (!winLast);
			start <= 1'b0;
			repeat (3) @(posedge clk);
		end
		while (owed != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		if (winCount != numFrames * winPerFrame) begin
			$display("expected %0d windows but received %0d", numFrames * winPerFrame,
				winCount);
			frameErr++;
		end
		total = dataErr + csErr + creditErr + ctrlErr + frameErr;
		$display("errors: data %0d, bank %0d, credit %0d, control %0d, count %0d",
			dataErr, csErr, creditErr, ctrlErr, frameErr);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* windowAssembler.sv */
`timescale 1ns/1ps

module windowAssembler (
	input logic clk,
	input logic rstn,
	input parserPkg::pixelWord bankData [parserPkg::numBanks],
	routeIf.asm routeIn,
	output logic winValid,
	output parserPkg::pixelWord winData [parserPkg::numBanks],
	output logic winLast
);
	import parserPkg::*;

	pixelWord slotWord [numBanks];

	// pick the source bank per slot, zero outside the frame
	always_comb begin
		for (int s = 0; s < numBanks; s++) begin
			if (routeIn.padMask[s])
				slotWord[s] = '0;
			else
				slotWord[s] = bankData[routeIn.srcBank[s]];
		end
	end

	////////////////////////////////////////////////////////////
	// output window register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			winValid <= 1'b0;
			winLast <= 1'b0;
		end else begin
			winValid <= routeIn.valid;
			winLast <= routeIn.valid && routeIn.last;
		end
	end

	always_ff @(posedge clk) begin
		if (routeIn.valid) begin
			for (int s = 0; s < numBanks; s++)
				winData[s] <= slotWord[s];
		end
	end

endmodule

/* windowRouteGen.sv */
`timescale 1ns/1ps

module windowRouteGen #(
	parameter int frameRows = parserPkg::defFrameRows,
	parameter int frameCols = parserPkg::defFrameCols
) (
	input logic clk,
	input logic rstn,
	scanIf.user scanIn,
	routeIf.gen routeOut
);
	import parserPkg::*;

	bankIdx srcNext [numBanks];
	logic [numBanks-1:0] padNext;
	logic lastNext;

	// first delay stage
	logic valid1;
	logic last1;
	bankIdx src1 [numBanks];
	logic [numBanks-1:0] pad1;

	////////////////////////////////////////////////////////////
	// slot to bank rotation and padding
	////////////////////////////////////////////////////////////
	always_comb begin
		logic [1:0] rowPh;
		logic [1:0] colPh;
		for (int s = 0; s < numBanks; s++) begin
			// (2r - 1 + i) mod 4 and (2c - 1 + j) mod 4
			rowPh = {scanIn.winRow[0], 1'b0} + 2'(s / 4) + 2'd3;
			colPh = {scanIn.winCol[0], 1'b0} + 2'(s % 4) + 2'd3;
			srcNext[s] = {rowPh, colPh};
			padNext[s] = ((scanIn.rowKind == sRowTop) && (s / 4 == 0))
				|| ((scanIn.rowKind == sRowBottom) && (s / 4 == 3))
				|| ((scanIn.winCol == '0) && (s % 4 == 0))
				|| ((scanIn.winCol == addrW'(frameCols / 2 - 1)) && (s % 4 == 3));
		end
	end

	assign lastNext = (scanIn.winRow == addrW'(frameRows / 2 - 1))
		&& (scanIn.winCol == addrW'(frameCols / 2 - 1));

	////////////////////////////////////////////////////////////
	// two cycle delay to meet the bank read data
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			valid1 <= 1'b0;
			last1 <= 1'b0;
			routeOut.valid <= 1'b0;
			routeOut.last <= 1'b0;
		end else begin
			valid1 <= scanIn.valid;
			last1 <= scanIn.valid && lastNext;
			routeOut.valid <= valid1;
			routeOut.last <= valid1 && last1;
		end
	end

	always_ff @(posedge clk) begin
		if (scanIn.valid) begin
			src1 <= srcNext;
			pad1 <= padNext;
		end
		if (valid1) begin
			routeOut.srcBank <= src1;
			routeOut.padMask <= pad1;
		end
	end

endmodule
